// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

  // Datapath and memory widths
  localparam int word_w    = 16;
  localparam int addr_w    = 9;
  localparam int reg_num_w = 3;
  localparam int num_regs  = 1 << reg_num_w;

  // Instruction field positions
  localparam int opc_hi  = 15;
  localparam int opc_lo  = 13;
  localparam int op_hi   = 12;
  localparam int op_lo   = 11;
  localparam int rn_hi   = 10;
  localparam int rn_lo   = 8;
  localparam int rd_hi   = 7;
  localparam int rd_lo   = 5;
  localparam int sh_hi   = 4;
  localparam int sh_lo   = 3;
  localparam int rm_hi   = 2;
  localparam int rm_lo   = 0;
  localparam int imm8_hi = 7;
  localparam int imm5_hi = 4;
  localparam int imm_lo  = 0;

  // MOV with op 10 takes the immediate form, op 00 the register form
  localparam logic [1:0] mov_imm_op = 2'b10;

  typedef logic [word_w-1:0]    word_t;
  typedef logic [addr_w-1:0]    addr_t;
  typedef logic [reg_num_w-1:0] reg_num_t;

  typedef enum logic [2:0] {
    op_branch = 3'b001,
    op_ldr    = 3'b011,
    op_str    = 3'b100,
    op_alu    = 3'b101,
    op_mov    = 3'b110,
    op_halt   = 3'b111
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_cmp = 2'b01,
    alu_and = 2'b10,
    alu_mvn = 2'b11
  } alu_op_e;

  typedef enum logic [1:0] {
    sh_none = 2'b00,
    sh_lsl1 = 2'b01,
    sh_lsr1 = 2'b10,
    sh_asr1 = 2'b11
  } shift_e;

  typedef enum logic [2:0] {
    c_always = 3'b000,
    c_eq     = 3'b001,
    c_ne     = 3'b010,
    c_lt     = 3'b011,
    c_le     = 3'b100
  } cond_e;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  // Decoded view of the instruction register
  typedef struct packed {
    opcode_e  opcode;
    alu_op_e  op;
    cond_e    cond;
    shift_e   shift;
    word_t    sximm5;
    word_t    sximm8;
    reg_num_t reg_num;
  } instr_t;

endpackage

// File: cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  localparam int state_w = 4;
  localparam int sel_w   = 2;

  typedef enum logic [state_w-1:0] {
    st_reset,
    st_if1,
    st_if2,
    st_update_pc,
    st_decode,
    st_load_a,
    st_load_b,
    st_alu,
    st_write_reg,
    st_mov_imm,
    st_addr,
    st_mem_wait,
    st_mem_write,
    st_halt
  } state_e;

  typedef enum logic [sel_w-1:0] {
    mem_none,
    mem_read,
    mem_write
  } mem_cmd_e;

  // Which instruction field addresses the register file
  typedef enum logic [sel_w-1:0] {
    sel_rn,
    sel_rd,
    sel_rm
  } reg_sel_e;

  typedef enum logic [sel_w-1:0] {
    wb_c,
    wb_imm8,
    wb_mdata
  } wb_sel_e;

  typedef enum logic [sel_w-1:0] {
    pc_inc,
    pc_branch,
    pc_zero
  } pc_sel_e;

  typedef struct packed {
    reg_sel_e reg_sel;
    logic     rf_write;
    wb_sel_e  wb_sel;
    logic     load_a;
    logic     load_b;
    logic     asel_zero;
    logic     bsel_imm5;
    logic     load_c;
    logic     load_s;
    logic     load_ir;
    logic     load_pc;
    pc_sel_e  pc_sel;
    logic     load_addr;
    logic     addr_sel_pc;
    mem_cmd_e mem_cmd;
  } ctrl_t;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  cpu_isa_pkg::word_t    mdata,
  input  cpu_ctrl_pkg::ctrl_t   ctrl,
  output cpu_isa_pkg::instr_t   instr
);

  cpu_isa_pkg::word_t    ir;
  cpu_isa_pkg::opcode_e  opcode;
  cpu_isa_pkg::reg_num_t rn;
  cpu_isa_pkg::reg_num_t rd;
  cpu_isa_pkg::reg_num_t rm;
  logic                  shift_used;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ctrl.load_ir) begin
      ir <= mdata;
    end
  end

  assign opcode = cpu_isa_pkg::opcode_e'(ir[cpu_isa_pkg::opc_hi:cpu_isa_pkg::opc_lo]);
  assign rn     = ir[cpu_isa_pkg::rn_hi:cpu_isa_pkg::rn_lo];
  assign rd     = ir[cpu_isa_pkg::rd_hi:cpu_isa_pkg::rd_lo];
  assign rm     = ir[cpu_isa_pkg::rm_hi:cpu_isa_pkg::rm_lo];

  // Bits 4:3 are part of imm5 for loads and stores, so only MOV and ALU shift
  assign shift_used = (opcode == cpu_isa_pkg::op_mov) || (opcode == cpu_isa_pkg::op_alu);

  always_comb begin
    instr.opcode = opcode;
    instr.op     = cpu_isa_pkg::alu_op_e'(ir[cpu_isa_pkg::op_hi:cpu_isa_pkg::op_lo]);
    instr.cond   = cpu_isa_pkg::cond_e'(ir[cpu_isa_pkg::rn_hi:cpu_isa_pkg::rn_lo]);
    instr.shift  = shift_used ?
                   cpu_isa_pkg::shift_e'(ir[cpu_isa_pkg::sh_hi:cpu_isa_pkg::sh_lo]) :
                   cpu_isa_pkg::sh_none;
    // Sign extension of the two immediates
    instr.sximm5 = {{(cpu_isa_pkg::word_w - cpu_isa_pkg::imm5_hi - 1){ir[cpu_isa_pkg::imm5_hi]}},
                    ir[cpu_isa_pkg::imm5_hi:cpu_isa_pkg::imm_lo]};
    instr.sximm8 = {{(cpu_isa_pkg::word_w - cpu_isa_pkg::imm8_hi - 1){ir[cpu_isa_pkg::imm8_hi]}},
                    ir[cpu_isa_pkg::imm8_hi:cpu_isa_pkg::imm_lo]};
    case (ctrl.reg_sel)
      cpu_ctrl_pkg::sel_rn: instr.reg_num = rn;
      cpu_ctrl_pkg::sel_rd: instr.reg_num = rd;
      default:              instr.reg_num = rm;
    endcase
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                clk,
  input  cpu_isa_pkg::instr_t instr,
  input  cpu_ctrl_pkg::ctrl_t ctrl,
  input  cpu_isa_pkg::word_t  c_value,
  input  cpu_isa_pkg::word_t  mdata,
  output cpu_isa_pkg::word_t  rd_data
);

  cpu_isa_pkg::word_t regs [0:cpu_isa_pkg::num_regs-1];
  cpu_isa_pkg::word_t wb_data;

  // Write-back source
  always_comb begin
    case (ctrl.wb_sel)
      cpu_ctrl_pkg::wb_c:    wb_data = c_value;
      cpu_ctrl_pkg::wb_imm8: wb_data = instr.sximm8;
      default:               wb_data = mdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.rf_write) begin
      regs[instr.reg_num] <= wb_data;
    end
  end

  // Read and write share the same register number
  assign rd_data = regs[instr.reg_num];

endmodule

// File: exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_ctrl_pkg::ctrl_t ctrl,
  input  cpu_isa_pkg::instr_t instr,
  input  cpu_isa_pkg::word_t  rd_data,
  output cpu_isa_pkg::word_t  out,
  output cpu_isa_pkg::flags_t flags
);

  localparam int msb = cpu_isa_pkg::word_w - 1;

  cpu_isa_pkg::word_t   a;
  cpu_isa_pkg::word_t   b;
  cpu_isa_pkg::word_t   c;
  cpu_isa_pkg::word_t   b_shifted;
  cpu_isa_pkg::word_t   ain;
  cpu_isa_pkg::word_t   bin;
  cpu_isa_pkg::word_t   alu_out;
  cpu_isa_pkg::alu_op_e alu_op;
  logic                 ovf;

  // Operand registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a <= '0;
      b <= '0;
    end else begin
      if (ctrl.load_a) begin
        a <= rd_data;
      end
      if (ctrl.load_b) begin
        b <= rd_data;
      end
    end
  end

  // One-bit shifter on B
  always_comb begin
    case (instr.shift)
      cpu_isa_pkg::sh_lsl1: b_shifted = {b[msb-1:0], 1'b0};
      cpu_isa_pkg::sh_lsr1: b_shifted = {1'b0, b[msb:1]};
      cpu_isa_pkg::sh_asr1: b_shifted = {b[msb], b[msb:1]};
      default:              b_shifted = b;
    endcase
  end

  assign ain = ctrl.asel_zero ? '0 : a;
  assign bin = ctrl.bsel_imm5 ? instr.sximm5 : b_shifted;

  // Address and move steps reuse the adder
  assign alu_op = (instr.opcode == cpu_isa_pkg::op_alu) ? instr.op : cpu_isa_pkg::alu_add;

  always_comb begin
    ovf = 1'b0;
    case (alu_op)
      cpu_isa_pkg::alu_add: begin
        alu_out = ain + bin;
        ovf     = (ain[msb] == bin[msb]) && (alu_out[msb] != ain[msb]);
      end
      cpu_isa_pkg::alu_cmp: begin
        alu_out = ain - bin;
        ovf     = (ain[msb] != bin[msb]) && (alu_out[msb] != ain[msb]);
      end
      cpu_isa_pkg::alu_and: alu_out = ain & bin;
      default:              alu_out = ~bin;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      c     <= '0;
      flags <= '0;
    end else begin
      if (ctrl.load_c) begin
        c <= alu_out;
      end
      if (ctrl.load_s) begin
        flags.z <= (alu_out == '0);
        flags.n <= alu_out[msb];
        flags.v <= ovf;
      end
    end
  end

  assign out = c;

endmodule

// File: pc_unit.sv
`timescale 1ns/1ns

module pc_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_ctrl_pkg::ctrl_t ctrl,
  input  cpu_isa_pkg::word_t  sximm8,
  input  cpu_isa_pkg::word_t  c_value,
  output cpu_isa_pkg::addr_t  mem_addr
);

  cpu_isa_pkg::addr_t pc;
  cpu_isa_pkg::addr_t pc_next;
  cpu_isa_pkg::addr_t target;
  cpu_isa_pkg::addr_t data_addr;

  // PC already points past the branch when the target is formed
  assign target = pc + sximm8[cpu_isa_pkg::addr_w-1:0];

  always_comb begin
    case (ctrl.pc_sel)
      cpu_ctrl_pkg::pc_inc:    pc_next = pc + 1'b1;
      cpu_ctrl_pkg::pc_branch: pc_next = target;
      default:                 pc_next = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ctrl.load_pc) begin
      pc <= pc_next;
    end
  end

  // Load and store address from the low bits of C
  always_ff @(posedge clk) begin
    if (ctrl.load_addr) begin
      data_addr <= c_value[cpu_isa_pkg::addr_w-1:0];
    end
  end

  assign mem_addr = ctrl.addr_sel_pc ? pc : data_addr;

endmodule

// File: control_fsm.sv
`timescale 1ns/1ns

module control_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_isa_pkg::instr_t    instr,
  input  cpu_isa_pkg::flags_t    flags,
  output cpu_ctrl_pkg::ctrl_t    ctrl,
  output cpu_ctrl_pkg::mem_cmd_e mem_cmd,
  output logic                   halted
);

  cpu_ctrl_pkg::state_e state;
  cpu_ctrl_pkg::state_e state_next;
  logic                 take;
  logic                 is_ldr;
  logic                 is_str;
  logic                 is_cmp;

  assign is_ldr = (instr.opcode == cpu_isa_pkg::op_ldr);
  assign is_str = (instr.opcode == cpu_isa_pkg::op_str);
  assign is_cmp = (instr.opcode == cpu_isa_pkg::op_alu) && (instr.op == cpu_isa_pkg::alu_cmp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cpu_ctrl_pkg::st_reset;
    end else begin
      state <= state_next;
    end
  end

  // Branch condition against the status flags
  always_comb begin
    case (instr.cond)
      cpu_isa_pkg::c_always: take = 1'b1;
      cpu_isa_pkg::c_eq:     take = flags.z;
      cpu_isa_pkg::c_ne:     take = !flags.z;
      cpu_isa_pkg::c_lt:     take = flags.n ^ flags.v;
      cpu_isa_pkg::c_le:     take = (flags.n ^ flags.v) | flags.z;
      default:               take = 1'b0;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      cpu_ctrl_pkg::st_reset:     state_next = cpu_ctrl_pkg::st_if1;
      cpu_ctrl_pkg::st_if1:       state_next = cpu_ctrl_pkg::st_if2;
      cpu_ctrl_pkg::st_if2:       state_next = cpu_ctrl_pkg::st_update_pc;
      cpu_ctrl_pkg::st_update_pc: state_next = cpu_ctrl_pkg::st_decode;
      cpu_ctrl_pkg::st_decode: begin
        case (instr.opcode)
          cpu_isa_pkg::op_mov:
            state_next = (instr.op == cpu_isa_pkg::mov_imm_op) ?
                         cpu_ctrl_pkg::st_mov_imm : cpu_ctrl_pkg::st_load_b;
          cpu_isa_pkg::op_alu,
          cpu_isa_pkg::op_ldr,
          cpu_isa_pkg::op_str:  state_next = cpu_ctrl_pkg::st_load_a;
          cpu_isa_pkg::op_halt: state_next = cpu_ctrl_pkg::st_halt;
          // Branches and unknown opcodes go straight to the next fetch
          default:              state_next = cpu_ctrl_pkg::st_if1;
        endcase
      end
      cpu_ctrl_pkg::st_load_a:
        state_next = (is_ldr || is_str) ? cpu_ctrl_pkg::st_alu : cpu_ctrl_pkg::st_load_b;
      cpu_ctrl_pkg::st_load_b:
        state_next = is_str ? cpu_ctrl_pkg::st_mem_wait : cpu_ctrl_pkg::st_alu;
      cpu_ctrl_pkg::st_alu: begin
        if (is_ldr || is_str) begin
          state_next = cpu_ctrl_pkg::st_addr;
        end else if (is_cmp) begin
          state_next = cpu_ctrl_pkg::st_if1;
        end else begin
          state_next = cpu_ctrl_pkg::st_write_reg;
        end
      end
      cpu_ctrl_pkg::st_addr:
        state_next = is_str ? cpu_ctrl_pkg::st_load_b : cpu_ctrl_pkg::st_mem_wait;
      cpu_ctrl_pkg::st_mem_wait:
        state_next = is_str ? cpu_ctrl_pkg::st_mem_write : cpu_ctrl_pkg::st_write_reg;
      cpu_ctrl_pkg::st_write_reg,
      cpu_ctrl_pkg::st_mov_imm,
      cpu_ctrl_pkg::st_mem_write: state_next = cpu_ctrl_pkg::st_if1;
      cpu_ctrl_pkg::st_halt:      state_next = cpu_ctrl_pkg::st_halt;
      default:                    state_next = cpu_ctrl_pkg::st_reset;
    endcase
  end

  // Control word per state
  always_comb begin
    ctrl = '0;
    ctrl.reg_sel     = cpu_ctrl_pkg::sel_rn;
    ctrl.wb_sel      = cpu_ctrl_pkg::wb_c;
    ctrl.pc_sel      = cpu_ctrl_pkg::pc_inc;
    ctrl.addr_sel_pc = 1'b1;
    ctrl.mem_cmd     = cpu_ctrl_pkg::mem_none;
    case (state)
      cpu_ctrl_pkg::st_reset: begin
        ctrl.load_pc = 1'b1;
        ctrl.pc_sel  = cpu_ctrl_pkg::pc_zero;
      end
      cpu_ctrl_pkg::st_if1: ctrl.mem_cmd = cpu_ctrl_pkg::mem_read;
      cpu_ctrl_pkg::st_if2: begin
        ctrl.mem_cmd = cpu_ctrl_pkg::mem_read;
        ctrl.load_ir = 1'b1;
      end
      cpu_ctrl_pkg::st_update_pc: ctrl.load_pc = 1'b1;
      cpu_ctrl_pkg::st_decode: begin
        // Not taken keeps the PC that already points to the next instruction
        if (instr.opcode == cpu_isa_pkg::op_branch) begin
          ctrl.pc_sel  = take ? cpu_ctrl_pkg::pc_branch : cpu_ctrl_pkg::pc_inc;
          ctrl.load_pc = take;
        end
      end
      cpu_ctrl_pkg::st_load_a: ctrl.load_a = 1'b1;
      cpu_ctrl_pkg::st_load_b: begin
        ctrl.reg_sel = is_str ? cpu_ctrl_pkg::sel_rd : cpu_ctrl_pkg::sel_rm;
        ctrl.load_b  = 1'b1;
      end
      cpu_ctrl_pkg::st_alu: begin
        ctrl.asel_zero = (instr.opcode == cpu_isa_pkg::op_mov);
        ctrl.bsel_imm5 = is_ldr || is_str;
        ctrl.load_c    = !is_cmp;
        ctrl.load_s    = (instr.opcode == cpu_isa_pkg::op_alu);
      end
      cpu_ctrl_pkg::st_write_reg: begin
        ctrl.reg_sel  = cpu_ctrl_pkg::sel_rd;
        ctrl.rf_write = 1'b1;
        if (is_ldr) begin
          ctrl.wb_sel      = cpu_ctrl_pkg::wb_mdata;
          ctrl.addr_sel_pc = 1'b0;
          ctrl.mem_cmd     = cpu_ctrl_pkg::mem_read;
        end
      end
      cpu_ctrl_pkg::st_mov_imm: begin
        ctrl.wb_sel   = cpu_ctrl_pkg::wb_imm8;
        ctrl.rf_write = 1'b1;
      end
      cpu_ctrl_pkg::st_addr: ctrl.load_addr = 1'b1;
      cpu_ctrl_pkg::st_mem_wait: begin
        ctrl.addr_sel_pc = 1'b0;
        // Store passes Rd through to C while a load starts the read
        if (is_str) begin
          ctrl.asel_zero = 1'b1;
          ctrl.load_c    = 1'b1;
        end else begin
          ctrl.mem_cmd = cpu_ctrl_pkg::mem_read;
        end
      end
      cpu_ctrl_pkg::st_mem_write: begin
        ctrl.addr_sel_pc = 1'b0;
        ctrl.mem_cmd     = cpu_ctrl_pkg::mem_write;
      end
      default: ctrl.load_pc = 1'b0;
    endcase
  end

  assign mem_cmd = ctrl.mem_cmd;
  assign halted  = (state == cpu_ctrl_pkg::st_halt);

endmodule

// File: cpu.sv
`timescale 1ns/1ns

module cpu (
  input  logic                   clk,
  input  logic                   rst_n,
  input  cpu_isa_pkg::word_t     mdata,
  output cpu_isa_pkg::addr_t     mem_addr,
  output cpu_ctrl_pkg::mem_cmd_e mem_cmd,
  output cpu_isa_pkg::word_t     out,
  output logic                   halted
);

  cpu_ctrl_pkg::ctrl_t ctrl;
  cpu_isa_pkg::instr_t instr;
  cpu_isa_pkg::flags_t flags;
  cpu_isa_pkg::word_t  rd_data;

  control_fsm u_control_fsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .instr   (instr),
    .flags   (flags),
    .ctrl    (ctrl),
    .mem_cmd (mem_cmd),
    .halted  (halted)
  );

  pc_unit u_pc_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl),
    .sximm8   (instr.sximm8),
    .c_value  (out),
    .mem_addr (mem_addr)
  );

  instr_decoder u_instr_decoder (
    .clk   (clk),
    .rst_n (rst_n),
    .mdata (mdata),
    .ctrl  (ctrl),
    .instr (instr)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .instr   (instr),
    .ctrl    (ctrl),
    .c_value (out),
    .mdata   (mdata),
    .rd_data (rd_data)
  );

  exec_unit u_exec_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .instr   (instr),
    .rd_data (rd_data),
    .out     (out),
    .flags   (flags)
  );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for four rising edges and released just after the last one
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// File: tb_mem.sv
`timescale 1ns/1ns

module tb_mem (
  input  logic                   clk,
  input  cpu_ctrl_pkg::mem_cmd_e mem_cmd,
  input  cpu_isa_pkg::addr_t     addr,
  input  cpu_isa_pkg::word_t     wdata,
  output cpu_isa_pkg::word_t     rdata
);

  localparam int depth = 1 << cpu_isa_pkg::addr_w;

  cpu_isa_pkg::word_t mem [0:depth-1];

  // Fill pattern carries the full address
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = 16'hb400 | 16'(i);
    end
  end

  // Read data follows the address within the same cycle
  assign rdata = (mem_cmd == cpu_ctrl_pkg::mem_read) ? mem[addr] : '0;

  always @(posedge clk) begin
    if (mem_cmd == cpu_ctrl_pkg::mem_write) begin
      mem[addr] <= wdata;
    end
  end

endmodule

// File: cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb;

  localparam int max_writes = 64;
  localparam int mem_depth  = 512;

  logic                   clk;
  logic                   rst_n;
  cpu_isa_pkg::word_t     mdata;
  cpu_isa_pkg::addr_t     mem_addr;
  cpu_ctrl_pkg::mem_cmd_e mem_cmd;
  cpu_isa_pkg::word_t     out;
  logic                   halted;

  // Model memory image and the predicted store sequence
  cpu_isa_pkg::word_t img [0:mem_depth-1];
  cpu_isa_pkg::addr_t exp_addr [0:max_writes-1];
  cpu_isa_pkg::word_t exp_data [0:max_writes-1];
  cpu_isa_pkg::addr_t poison_addr = 9'h1e0;
  int                 exp_count = 0;
  int                 wr_idx = 0;
  int                 errors = 0;
  int                 prog_len = 0;
  int                 steps = 0;
  int                 limit_cycles = 0;
  logic               model_done = 1'b0;
  logic               model_halted = 1'b0;
  logic               seen_read = 1'b0;
  logic [31:0]        seed = 32'd3;

  tb_clk_gen clk_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tb_mem mem_i (
    .clk     (clk),
    .mem_cmd (mem_cmd),
    .addr    (mem_addr),
    .wdata   (out),
    .rdata   (mdata)
  );

  cpu dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .mdata    (mdata),
    .mem_addr (mem_addr),
    .mem_cmd  (mem_cmd),
    .out      (out),
    .halted   (halted)
  );

  function automatic logic [15:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[30:15];
  endfunction

  function automatic cpu_isa_pkg::word_t mov_imm(input int rn, input logic [7:0] imm);
    return {cpu_isa_pkg::op_mov, cpu_isa_pkg::mov_imm_op, 3'(rn), imm};
  endfunction

  function automatic cpu_isa_pkg::word_t mov_reg(input int rd, input int rm, input int sh);
    return {cpu_isa_pkg::op_mov, 2'b00, 3'b000, 3'(rd), 2'(sh), 3'(rm)};
  endfunction

  function automatic cpu_isa_pkg::word_t alu_instr(input logic [1:0] op, input int rn,
                                                   input int rd, input int rm, input int sh);
    return {cpu_isa_pkg::op_alu, op, 3'(rn), 3'(rd), 2'(sh), 3'(rm)};
  endfunction

  function automatic cpu_isa_pkg::word_t ldst(input logic [2:0] opc, input int rn,
                                              input int rd, input int imm5);
    return {opc, 2'b00, 3'(rn), 3'(rd), 5'(imm5)};
  endfunction

  function automatic cpu_isa_pkg::word_t branch(input logic [2:0] cond, input int off);
    return {cpu_isa_pkg::op_branch, 2'b00, cond, 8'(off)};
  endfunction

  function automatic cpu_isa_pkg::word_t shift_word(input cpu_isa_pkg::word_t x,
                                                    input logic [1:0] sh);
    case (sh)
      2'b01:   return {x[14:0], 1'b0};
      2'b10:   return {1'b0, x[15:1]};
      2'b11:   return {x[15], x[15:1]};
      default: return x;
    endcase
  endfunction

  task automatic put_word(input cpu_isa_pkg::addr_t a, input cpu_isa_pkg::word_t w);
    img[a] = w;
    mem_i.mem[a] = w;
  endtask

  task automatic emit(input cpu_isa_pkg::word_t w);
    put_word(9'(prog_len), w);
    prog_len++;
  endtask

  task automatic build_program();
    logic [15:0] x;
    logic [15:0] y;
    // Data operations with results stored from 0x180
    emit(mov_imm(0, 8'(next_rand() >> 8)));
    emit(mov_imm(1, 8'(next_rand() >> 8)));
    emit(mov_imm(7, 8'h80));
    for (int s = 0; s < 4; s++) begin
      emit(mov_reg(3, 0, s));
      emit(ldst(cpu_isa_pkg::op_str, 7, 3, s));
    end
    emit(alu_instr(cpu_isa_pkg::alu_add, 0, 3, 1, next_rand() % 4));
    emit(ldst(cpu_isa_pkg::op_str, 7, 3, 4));
    emit(alu_instr(cpu_isa_pkg::alu_and, 0, 4, 1, next_rand() % 4));
    emit(ldst(cpu_isa_pkg::op_str, 7, 4, 5));
    emit(alu_instr(cpu_isa_pkg::alu_mvn, 0, 5, 1, next_rand() % 4));
    emit(ldst(cpu_isa_pkg::op_str, 7, 5, 6));
    // Load path from preloaded words at 0x1c0
    emit(mov_imm(6, 8'hc0));
    for (int j = 0; j < 3; j++) begin
      put_word(9'(9'h1c0 + j), next_rand());
      emit(ldst(cpu_isa_pkg::op_ldr, 6, 3, j));
      emit(ldst(cpu_isa_pkg::op_str, 7, 3, 7 + j));
    end
    // Markers go to 0x1a0 and the poison address sits in R5
    emit(mov_imm(2, 8'ha0));
    emit(mov_imm(3, 8'h3c));
    emit(mov_imm(4, 8'h5a));
    emit(mov_imm(5, 8'he0));
    // Compare operands are preloaded words at 0x1d0 and 0x1c3
    emit(mov_imm(6, 8'hd0));
    for (int i = 0; i < 12; i++) begin
      x = next_rand();
      y = next_rand();
      // Every third pair is equal so EQ and LE also get taken
      if (i % 3 == 0) begin
        y = x;
      end else if (i % 3 == 1) begin
        // Large positive minus large negative sets v
        x = {2'b01, x[13:0]};
        y = {2'b10, y[13:0]};
      end
      put_word(9'(9'h1d0 + i), x);
      put_word(9'(9'h1c3 + i), y);
      emit(ldst(cpu_isa_pkg::op_ldr, 6, 0, i));
      emit(ldst(cpu_isa_pkg::op_ldr, 6, 1, i - 13));
      emit(alu_instr(cpu_isa_pkg::alu_cmp, 0, 0, 1, 0));
      emit(branch(3'(i % 4 + 1), 3));
      emit(ldst(cpu_isa_pkg::op_str, 2, 3, i));
      emit(branch(cpu_isa_pkg::c_always, 2));
      emit(ldst(cpu_isa_pkg::op_str, 5, 0, 0));
      emit(ldst(cpu_isa_pkg::op_str, 2, 4, i));
    end
    emit({cpu_isa_pkg::op_halt, 13'b0});
    // Never fetched once the processor halts
    emit(ldst(cpu_isa_pkg::op_str, 5, 0, 0));
  endtask

  // Instruction-level model of the ISA that records every store
  task automatic run_model();
    cpu_isa_pkg::word_t r [0:7];
    cpu_isa_pkg::word_t ir;
    cpu_isa_pkg::word_t a;
    cpu_isa_pkg::word_t b;
    cpu_isa_pkg::word_t res;
    cpu_isa_pkg::word_t ea;
    cpu_isa_pkg::word_t imm8;
    cpu_isa_pkg::addr_t pc;
    logic               z;
    logic               n;
    logic               v;
    logic               take;
    int                 sum;
    pc = '0;
    z = 1'b0;
    n = 1'b0;
    v = 1'b0;
    for (int i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    while (!model_halted && steps < 2000) begin
      ir = img[pc];
      pc = pc + 1'b1;
      steps++;
      imm8 = {{8{ir[7]}}, ir[7:0]};
      ea   = r[ir[10:8]] + {{11{ir[4]}}, ir[4:0]};
      b    = shift_word(r[ir[2:0]], ir[4:3]);
      case (ir[15:13])
        cpu_isa_pkg::op_mov: begin
          if (ir[12:11] == 2'b10) begin
            r[ir[10:8]] = imm8;
          end else begin
            r[ir[7:5]] = b;
          end
        end
        cpu_isa_pkg::op_alu: begin
          a = r[ir[10:8]];
          case (ir[12:11])
            2'b00: begin
              res = a + b;
              sum = $signed(a) + $signed(b);
            end
            2'b01: begin
              res = a - b;
              sum = $signed(a) - $signed(b);
            end
            2'b10: begin
              res = a & b;
              sum = 0;
            end
            default: begin
              res = ~b;
              sum = 0;
            end
          endcase
          if (ir[12:11] != 2'b01) begin
            r[ir[7:5]] = res;
          end
          z = (res == '0);
          n = res[15];
          v = (sum > 32767) || (sum < -32768);
        end
        cpu_isa_pkg::op_ldr: r[ir[7:5]] = img[ea[8:0]];
        cpu_isa_pkg::op_str: begin
          img[ea[8:0]] = r[ir[7:5]];
          exp_addr[exp_count] = ea[8:0];
          exp_data[exp_count] = r[ir[7:5]];
          exp_count++;
        end
        cpu_isa_pkg::op_branch: begin
          case (ir[10:8])
            cpu_isa_pkg::c_always: take = 1'b1;
            cpu_isa_pkg::c_eq:     take = z;
            cpu_isa_pkg::c_ne:     take = !z;
            cpu_isa_pkg::c_lt:     take = (n != v);
            cpu_isa_pkg::c_le:     take = (n != v) || z;
            default:               take = 1'b0;
          endcase
          if (take) begin
            pc = pc + imm8[8:0];
          end
        end
        cpu_isa_pkg::op_halt: model_halted = 1'b1;
        default: take = 1'b0;
      endcase
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && mem_cmd == cpu_ctrl_pkg::mem_write) begin
      wr_idx <= wr_idx + 1;
    end
    if (rst_n && mem_cmd == cpu_ctrl_pkg::mem_read) begin
      seen_read <= 1'b1;
    end
  end

  // Checks sample at the falling edge where all DUT outputs are settled
  assert property (@(negedge clk) !rst_n |-> mem_cmd == cpu_ctrl_pkg::mem_none)
    else begin
      errors++;
      $display("Fail mem_cmd in reset: expected %h, got %h", cpu_ctrl_pkg::mem_none, mem_cmd);
    end

  assert property (@(negedge clk) !rst_n |-> !halted)
    else begin
      errors++;
      $display("Fail halted in reset: expected 0, got %h", halted);
    end

  assert property (@(negedge clk)
                   (rst_n && mem_cmd == cpu_ctrl_pkg::mem_read && !seen_read) |-> mem_addr == '0)
    else begin
      errors++;
      $display("Fail mem_addr on first fetch: expected 000, got %h", mem_addr);
    end

  assert property (@(negedge clk)
                   (rst_n && mem_cmd == cpu_ctrl_pkg::mem_write) |-> wr_idx < exp_count)
    else begin
      errors++;
      $display("Memory write at %h beyond the predicted sequence", mem_addr);
    end

  assert property (@(negedge clk) (rst_n && mem_cmd == cpu_ctrl_pkg::mem_write &&
                   wr_idx < exp_count) |-> mem_addr == exp_addr[wr_idx])
    else begin
      errors++;
      $display("Fail mem_addr on write %0d: expected %h, got %h",
               wr_idx, exp_addr[wr_idx], mem_addr);
    end

  assert property (@(negedge clk) (rst_n && mem_cmd == cpu_ctrl_pkg::mem_write &&
                   wr_idx < exp_count) |-> out == exp_data[wr_idx])
    else begin
      errors++;
      $display("Fail out on write %0d: expected %h, got %h", wr_idx, exp_data[wr_idx], out);
    end

  assert property (@(negedge clk)
                   (rst_n && mem_cmd == cpu_ctrl_pkg::mem_write) |-> mem_addr != poison_addr)
    else begin
      errors++;
      $display("A store skipped by a branch wrote the poison address %h", mem_addr);
    end

  assert property (@(negedge clk) disable iff (!rst_n) halted |=> halted)
    else begin
      errors++;
      $display("Fail halted after HALT: expected 1, got %h", halted);
    end

  assert property (@(negedge clk) halted |-> mem_cmd == cpu_ctrl_pkg::mem_none)
    else begin
      errors++;
      $display("Fail mem_cmd while halted: expected %h, got %h", cpu_ctrl_pkg::mem_none, mem_cmd);
    end

  initial begin
    for (int i = 0; i < mem_depth; i++) begin
      img[i] = '0;
    end
    // Program goes in after the memory fill at time zero
    #1;
    build_program();
    run_model();
    limit_cycles = steps * 12 + 100;
    model_done = 1'b1;
    wait (halted === 1'b1);
    // Watch the halted state for a while
    repeat (20) @(posedge clk);
    assert (wr_idx == exp_count)
      else begin
        errors++;
        $display("Fail write count: expected %h, got %h", exp_count, wr_idx);
      end
    $display("Checks done: %0d of %0d writes seen, %0d errors", wr_idx, exp_count, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the executed instruction count
  initial begin
    wait (model_done);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the program did not reach HALT within %0d cycles", limit_cycles);
    $display("Checks done: %0d of %0d writes seen, %0d errors", wr_idx, exp_count, errors + 1);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: project.f
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
instr_decoder.sv
reg_file.sv
exec_unit.sv
pc_unit.sv
control_fsm.sv
cpu.sv
tb_clk_gen.sv
tb_mem.sv
cpu_tb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - files:
      - cpu_isa_pkg.sv
      - cpu_ctrl_pkg.sv
      - instr_decoder.sv
      - reg_file.sv
      - exec_unit.sv
      - pc_unit.sv
      - control_fsm.sv
      - cpu.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_mem.sv
      - cpu_tb.sv
